//--- Makefile
SIM := obj_dir/Vgt_link_tb
SRCS := vlog.f $(wildcard verilog/*.sv verification/*.sv include/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SRCS)
	verilator --binary --timing -j 0 --timescale 1ns/100ps \
		--top-module gt_link_tb -f vlog.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- include/gt_link_defines.svh
`ifndef GT_LINK_DEFINES_SVH
`define GT_LINK_DEFINES_SVH

// Lane width
`define GT_DWIDTH 16
`define GT_DBYTE (`GT_DWIDTH / 8)

// K28.5 comma in byte 0, sent until the reset chain completes
`define GT_IDLE_WORD {{(`GT_DWIDTH - 8){1'b0}}, 8'hBC}
`define GT_IDLE_KMASK {{(`GT_DBYTE - 1){1'b0}}, 1'b1}

// Channel model delays, in RXUSRCLK cycles
`define GT_CPLL_LOCK_DELAY 20
`define GT_RESET_DONE_DELAY 15
`define GT_CDR_LOCK_DELAY 8
`define GT_LOOP_LATENCY 3

// Unlocked cycles tolerated before link lock drops
`define GT_LOCK_HOLD 3

// Reset chain step timing
`define GT_RST_LENGTH 10
`define GT_RST_TO_CHECK 4
`define GT_RDY_LENGTH 6
`define GT_RST_TIMEOUT 200

`endif

//--- verification/gt_link_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "gt_link_defines.svh"

module gt_link_tb
	import gt_link_pkg::*;
();

	localparam int MAX_CYCLES = 3000;

	logic RXUSRCLK;
	logic reset;
	gt_data_t tx_data;
	gt_kmask_t tx_charisk;
	logic rx_user_ready;
	logic rx_signal_loss;
	gt_data_t rx_data;
	gt_kmask_t rx_charisk;
	gt_kmask_t rx_disperr;
	gt_kmask_t rx_notintable;
	logic reset_done;
	logic locked;
	logic cdr_lock;

	integer seed;
	int errors = 0;
	int checks = 0;
	int cycle_count = 0;
	string test_name;

	// Expected receive words, oldest first
	gt_data_t exp_data[$];
	gt_kmask_t exp_k[$];
	gt_kmask_t exp_derr[$];
	gt_kmask_t exp_nit[$];
	logic synced;

	gt_link_wrap dut_i (
		.RXUSRCLK(RXUSRCLK),
		.reset(reset),
		.tx_data(tx_data),
		.tx_charisk(tx_charisk),
		.rx_user_ready(rx_user_ready),
		.rx_signal_loss(rx_signal_loss),
		.rx_data(rx_data),
		.rx_charisk(rx_charisk),
		.rx_disperr(rx_disperr),
		.rx_notintable(rx_notintable),
		.reset_done(reset_done),
		.locked(locked),
		.cdr_lock(cdr_lock)
	);

	always #20 RXUSRCLK = ~RXUSRCLK;

	always @(posedge RXUSRCLK) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Run stopped after %0d cycles with tests still running", cycle_count);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic check_data(input string name, input gt_data_t exp, input gt_data_t act);
		checks++;
		if (act !== exp) begin
			$display("ERROR %s: expected %h, got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_kmask(input string name, input gt_kmask_t exp, input gt_kmask_t act);
		checks++;
		if (act !== exp) begin
			$display("ERROR %s: expected %b, got %b", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			$display("ERROR %s: expected %b, got %b", name, exp, act);
			errors++;
		end
	endtask

	// Inputs change 2 ns after the edge, outputs are read at the same point
	task automatic tick();
		@(posedge RXUSRCLK);
		#2;
	endtask

	task automatic clear_expected();
		exp_data.delete();
		exp_k.delete();
		exp_derr.delete();
		exp_nit.delete();
		synced = 1'b0;
	endtask

	// Matching starts at the first received word equal to the oldest one sent
	task automatic check_rx();
		if (exp_data.size() == 0)
			return;
		if (!synced) begin
			if (rx_data !== exp_data[0] || rx_charisk !== exp_k[0])
				return;
			synced = 1'b1;
		end
		check_data({test_name, " rx_data"}, exp_data[0], rx_data);
		check_kmask({test_name, " rx_charisk"}, exp_k[0], rx_charisk);
		check_kmask({test_name, " rx_disperr"}, exp_derr[0], rx_disperr);
		check_kmask({test_name, " rx_notintable"}, exp_nit[0], rx_notintable);
		void'(exp_data.pop_front());
		void'(exp_k.pop_front());
		void'(exp_derr.pop_front());
		void'(exp_nit.pop_front());
	endtask

	task automatic xfer(input gt_data_t d, input gt_kmask_t k, input logic loss,
		input gt_kmask_t nit);
		gt_kmask_t derr;
		derr = {`GT_DBYTE{loss}};
		tx_data = d;
		tx_charisk = k;
		rx_signal_loss = loss;
		exp_data.push_back(d);
		exp_k.push_back(k);
		exp_derr.push_back(derr);
		exp_nit.push_back(nit);
		tick();
		check_rx();
	endtask

	task automatic flush();
		int n;
		n = 0;
		tx_data = '0;
		tx_charisk = '0;
		rx_signal_loss = 1'b0;
		while (exp_data.size() != 0 && n < 10) begin
			tick();
			check_rx();
			n++;
		end
		if (exp_data.size() != 0) begin
			$display("%s: %0d sent words never came back", test_name, exp_data.size());
			errors++;
		end
		clear_expected();
	endtask

	// K bytes only ever carry K28.5
	task automatic random_word(output gt_data_t d, output gt_kmask_t k);
		logic [31:0] r;
		r = $random(seed);
		d = r[`GT_DWIDTH-1:0];
		r = $random(seed);
		k = r[`GT_DBYTE-1:0];
		for (int b = 0; b < `GT_DBYTE; b++) begin
			if (k[b])
				d[8*b +: 8] = 8'hBC;
		end
	endtask

	task automatic send_random(input int count);
		gt_data_t d;
		gt_kmask_t k;
		repeat (count) begin
			random_word(d, k);
			xfer(d, k, 1'b0, '0);
		end
	endtask

	task automatic wait_locked(input int limit);
		int n;
		n = 0;
		while (!locked && n < limit) begin
			tick();
			n++;
		end
		if (!locked) begin
			$display("%s: link lock did not come back within %0d cycles", test_name, limit);
			errors++;
		end
	endtask

	task automatic reset_sequence();
		int n;
		test_name = "reset_sequence";
		n = 0;
		while (!reset_done && n < 200) begin
			// Comma goes out in place of the user word
			check_data({test_name, " tx word"}, `GT_IDLE_WORD, dut_i.gt_tx_data);
			check_kmask({test_name, " tx charisk"}, `GT_IDLE_KMASK, dut_i.gt_tx_charisk);
			tick();
			n++;
		end
		if (!reset_done) begin
			$display("reset_sequence: reset_done still low 200 cycles after reset release");
			errors++;
			return;
		end
		wait_locked(50);
		repeat (10) begin
			tick();
			check_bit({test_name, " reset_done"}, 1'b1, reset_done);
			check_bit({test_name, " cdr_lock"}, 1'b1, cdr_lock);
		end
	endtask

	task automatic loopback_data();
		test_name = "loopback_data";
		send_random(64);
		flush();
	endtask

	task automatic illegal_k_code();
		test_name = "illegal_k_code";
		// 0x55 is no K code, byte 0 stays a legal comma
		xfer({8'h55, 8'hBC}, 2'b11, 1'b0, 2'b10);
		flush();
	endtask

	task automatic short_signal_loss();
		gt_data_t d;
		gt_kmask_t k;
		test_name = "short_signal_loss";
		send_random(4);
		repeat (`GT_LOCK_HOLD - 1) begin
			random_word(d, k);
			xfer(d, k, 1'b1, '0);
			check_bit({test_name, " cdr_lock"}, 1'b0, cdr_lock);
			check_bit({test_name, " locked"}, 1'b1, locked);
		end
		repeat (6) begin
			random_word(d, k);
			xfer(d, k, 1'b0, '0);
			check_bit({test_name, " locked"}, 1'b1, locked);
		end
		flush();
	endtask

	task automatic long_signal_loss();
		test_name = "long_signal_loss";
		// Nonzero word with an illegal K byte, so every output would show it
		tx_data = ~`GT_IDLE_WORD;
		tx_charisk = ~`GT_IDLE_KMASK;
		rx_signal_loss = 1'b1;
		repeat (20) tick();
		check_bit({test_name, " cdr_lock"}, 1'b0, cdr_lock);
		check_bit({test_name, " locked"}, 1'b0, locked);
		check_data({test_name, " rx_data"}, '0, rx_data);
		check_kmask({test_name, " rx_charisk"}, '0, rx_charisk);
		check_kmask({test_name, " rx_disperr"}, '0, rx_disperr);
		check_kmask({test_name, " rx_notintable"}, '0, rx_notintable);
		rx_signal_loss = 1'b0;
		wait_locked(20);
		send_random(16);
		flush();
	endtask

	task automatic reset_rerun();
		test_name = "reset_rerun";
		send_random(6);
		reset = 1'b1;
		#1;
		check_bit({test_name, " reset_done"}, 1'b0, reset_done);
		clear_expected();
		tx_data = ~`GT_IDLE_WORD;
		tx_charisk = ~`GT_IDLE_KMASK;
		repeat (5) tick();
		reset = 1'b0;
		reset_sequence();
		test_name = "reset_rerun";
		send_random(16);
		flush();
	endtask

	initial begin
		seed = 53300;
		RXUSRCLK = 1'b0;
		reset = 1'b1;
		tx_data = ~`GT_IDLE_WORD;
		tx_charisk = ~`GT_IDLE_KMASK;
		rx_user_ready = 1'b0;
		rx_signal_loss = 1'b0;
		clear_expected();
		repeat (5) tick();
		reset = 1'b0;
		rx_user_ready = 1'b1;

		reset_sequence();
		loopback_data();
		illegal_k_code();
		short_signal_loss();
		long_signal_loss();
		reset_rerun();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/cdr_lock_filter.sv
`timescale 1ns/100ps
`default_nettype none

`include "gt_link_defines.svh"

module cdr_lock_filter (
	input wire RXUSRCLK,
	input wire reset,
	input wire cdr_lock,
	output logic locked
);

	localparam int CNT_W = $clog2(`GT_LOCK_HOLD + 1);
	localparam logic [CNT_W-1:0] HOLD = CNT_W'(`GT_LOCK_HOLD);

	// Consecutive cycles without CDR lock, saturating at HOLD
	logic [CNT_W-1:0] unlock_cnt;

	always_ff @(posedge RXUSRCLK or posedge reset) begin
		if (reset) begin
			unlock_cnt <= '0;
			locked <= 1'b0;
		end else if (cdr_lock) begin
			unlock_cnt <= '0;
			locked <= 1'b1;
		end else if (unlock_cnt != HOLD) begin
			unlock_cnt <= unlock_cnt + 1'b1;
			// Drop only once the gap reaches the hold length
			if (unlock_cnt == HOLD - 1'b1) begin
				locked <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/chain_reset.sv
`timescale 1ns/100ps
`default_nettype none

`include "gt_link_defines.svh"

module chain_reset
	import gt_link_pkg::*;
#(
	parameter int NSTEP = 3
) (
	input wire RXUSRCLK,
	input wire reset,
	input wire [NSTEP-1:0] done_criteria,
	output logic [NSTEP-1:0] reset_out,
	output logic [NSTEP-1:0] done
);

	localparam int CNT_W = $clog2(`GT_RST_TIMEOUT + `GT_RST_LENGTH + `GT_RST_TO_CHECK);
	localparam int RDY_W = $clog2(`GT_RDY_LENGTH + 1);

	localparam logic [CNT_W-1:0] LEN_LAST = CNT_W'(`GT_RST_LENGTH - 1);
	localparam logic [CNT_W-1:0] CHECK_LAST = CNT_W'(`GT_RST_TO_CHECK - 1);
	localparam logic [CNT_W-1:0] TIMEOUT_LAST = CNT_W'(`GT_RST_TIMEOUT - 1);
	localparam logic [RDY_W-1:0] RDY_LAST = RDY_W'(`GT_RDY_LENGTH - 1);

	reset_step_t state [NSTEP];
	logic [CNT_W-1:0] cnt [NSTEP];
	logic [RDY_W-1:0] rdy_cnt [NSTEP];

	logic [NSTEP-1:0] prev_done;
	logic [NSTEP-1:0] step_busy;
	logic [NSTEP-1:0] later_busy;

	for (genvar g = 0; g < NSTEP; g++) begin : g_step
		assign reset_out[g] = (state[g] == STEP_ASSERT) || (state[g] == STEP_TIMEOUT);
		assign done[g] = (state[g] == STEP_DONE);
		assign step_busy[g] = (state[g] != STEP_IDLE) && (state[g] != STEP_DONE);

		if (g == 0) begin : g_first
			assign prev_done[g] = 1'b1;
		end else begin : g_rest
			assign prev_done[g] = &done[g-1:0];
		end

		// A later step in progress disturbs the shared criterion on purpose
		if (g == NSTEP - 1) begin : g_last
			assign later_busy[g] = 1'b0;
		end else begin : g_more
			assign later_busy[g] = |step_busy[NSTEP-1:g+1];
		end
	end

	always_ff @(posedge RXUSRCLK or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < NSTEP; i++) begin
				state[i] <= STEP_ASSERT;
				cnt[i] <= '0;
				rdy_cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NSTEP; i++) begin
				if (!prev_done[i]) begin
					// Wait with reset released until earlier steps finish
					state[i] <= STEP_IDLE;
					cnt[i] <= '0;
					rdy_cnt[i] <= '0;
				end else begin
					case (state[i])
						STEP_IDLE: begin
							state[i] <= STEP_ASSERT;
							cnt[i] <= '0;
						end
						STEP_ASSERT: begin
							if (cnt[i] == LEN_LAST) begin
								state[i] <= STEP_SETTLE;
								cnt[i] <= '0;
							end else begin
								cnt[i] <= cnt[i] + 1'b1;
							end
						end
						STEP_SETTLE: begin
							if (cnt[i] == CHECK_LAST) begin
								state[i] <= STEP_QUALIFY;
								cnt[i] <= '0;
								rdy_cnt[i] <= '0;
							end else begin
								cnt[i] <= cnt[i] + 1'b1;
							end
						end
						STEP_QUALIFY: begin
							if (done_criteria[i] && rdy_cnt[i] == RDY_LAST) begin
								state[i] <= STEP_DONE;
							end else if (cnt[i] == TIMEOUT_LAST) begin
								state[i] <= STEP_TIMEOUT;
							end else begin
								cnt[i] <= cnt[i] + 1'b1;
								rdy_cnt[i] <= done_criteria[i] ? rdy_cnt[i] + 1'b1 : '0;
							end
						end
						STEP_DONE: begin
							// Criterion lost, later steps follow via prev_done
							if (!done_criteria[i] && !later_busy[i]) begin
								state[i] <= STEP_ASSERT;
								cnt[i] <= '0;
							end
						end
						STEP_TIMEOUT: begin
							state[i] <= STEP_ASSERT;
							cnt[i] <= '0;
						end
						default: begin
							state[i] <= STEP_ASSERT;
							cnt[i] <= '0;
						end
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/gt_channel_model.sv
`timescale 1ns/100ps
`default_nettype none

`include "gt_link_defines.svh"

module gt_channel_model
	import gt_link_pkg::*;
(
	input wire RXUSRCLK,
	input wire reset,
	input wire cpll_reset,
	input wire gt_reset,
	input wire rx_signal_loss,
	input wire rx_user_ready,
	input wire gt_data_t tx_data,
	input wire gt_kmask_t tx_charisk,
	output logic cpll_lock,
	output logic tx_reset_done,
	output logic rx_reset_done,
	output logic cdr_lock,
	output gt_data_t rx_data,
	output gt_kmask_t rx_charisk,
	output gt_kmask_t rx_disperr,
	output gt_kmask_t rx_notintable
);

	localparam int CNT_W =
		$clog2(`GT_CPLL_LOCK_DELAY + `GT_RESET_DONE_DELAY + `GT_CDR_LOCK_DELAY + 1);
	localparam int LAT = `GT_LOOP_LATENCY;

	localparam logic [CNT_W-1:0] CPLL_DELAY = CNT_W'(`GT_CPLL_LOCK_DELAY);
	localparam logic [CNT_W-1:0] DONE_DELAY = CNT_W'(`GT_RESET_DONE_DELAY);
	localparam logic [CNT_W-1:0] CDR_DELAY = CNT_W'(`GT_CDR_LOCK_DELAY);

	logic [CNT_W-1:0] cpll_cnt;
	logic [CNT_W-1:0] rst_cnt;
	logic [CNT_W-1:0] cdr_cnt;

	// Words in flight; the output register is the last stage
	gt_data_t [LAT-2:0] pipe_data;
	gt_kmask_t [LAT-2:0] pipe_k;
	logic [LAT-2:0] pipe_loss;

	gt_kmask_t bad_k;

	function automatic logic [CNT_W-1:0] sat_inc(
		input logic [CNT_W-1:0] count,
		input logic [CNT_W-1:0] limit
	);
		return (count < limit) ? count + 1'b1 : count;
	endfunction

	// K28.x, K23.7, K27.7, K29.7, K30.7
	function automatic logic is_legal_k(input logic [7:0] code);
		return (code[4:0] == 5'b11100) || (code == 8'hF7) || (code == 8'hFB) ||
			(code == 8'hFD) || (code == 8'hFE);
	endfunction

	always_ff @(posedge RXUSRCLK or posedge reset) begin
		if (reset) begin
			cpll_cnt <= '0;
			rst_cnt <= '0;
			cdr_cnt <= '0;
			cpll_lock <= 1'b0;
			tx_reset_done <= 1'b0;
			rx_reset_done <= 1'b0;
			cdr_lock <= 1'b0;
		end else begin
			if (cpll_reset) begin
				cpll_cnt <= '0;
			end else begin
				cpll_cnt <= sat_inc(cpll_cnt, CPLL_DELAY);
			end
			cpll_lock <= !cpll_reset && (cpll_cnt == CPLL_DELAY);

			// Datapath reset completes only on a locked PLL
			if (gt_reset || !cpll_lock) begin
				rst_cnt <= '0;
			end else begin
				rst_cnt <= sat_inc(rst_cnt, DONE_DELAY);
			end
			tx_reset_done <= !gt_reset && cpll_lock && (rst_cnt == DONE_DELAY);
			// RX PCS finishes a cycle behind TX
			rx_reset_done <= !gt_reset && tx_reset_done;

			if (!rx_reset_done) begin
				cdr_cnt <= '0;
			end else begin
				cdr_cnt <= sat_inc(cdr_cnt, CDR_DELAY);
			end
			// Signal loss masks lock without losing the trained state
			cdr_lock <= rx_reset_done && !rx_signal_loss && (cdr_cnt == CDR_DELAY);
		end
	end

	always_ff @(posedge RXUSRCLK) begin
		pipe_data[0] <= tx_data;
		pipe_k[0] <= tx_charisk;
		pipe_loss[0] <= rx_signal_loss;
		for (int i = 1; i < LAT - 1; i++) begin
			pipe_data[i] <= pipe_data[i-1];
			pipe_k[i] <= pipe_k[i-1];
			pipe_loss[i] <= pipe_loss[i-1];
		end
	end

	always_comb begin
		for (int b = 0; b < `GT_DBYTE; b++) begin
			bad_k[b] = pipe_k[LAT-2][b] && !is_legal_k(pipe_data[LAT-2][8*b +: 8]);
		end
	end

	always_ff @(posedge RXUSRCLK or posedge reset) begin
		if (reset) begin
			rx_data <= '0;
			rx_charisk <= '0;
			rx_disperr <= '0;
			rx_notintable <= '0;
		end else if (rx_user_ready) begin
			rx_data <= pipe_data[LAT-2];
			rx_charisk <= pipe_k[LAT-2];
			rx_disperr <= {`GT_DBYTE{pipe_loss[LAT-2]}};
			rx_notintable <= bad_k;
		end else begin
			rx_data <= '0;
			rx_charisk <= '0;
			rx_disperr <= '0;
			rx_notintable <= '0;
		end
	end

endmodule

`default_nettype wire

//--- verilog/gt_link_pkg.sv
`default_nettype none

package gt_link_pkg;

`include "gt_link_defines.svh"

	// One lane word
	typedef logic [`GT_DWIDTH-1:0] gt_data_t;

	// One flag per lane byte: charisk, disperr, notintable
	typedef logic [`GT_DBYTE-1:0] gt_kmask_t;

	// Reset chain step progress
	typedef enum logic [2:0] {
		STEP_IDLE,
		// Reset held, length counting
		STEP_ASSERT,
		STEP_SETTLE,
		// Waiting for the criterion to stay high
		STEP_QUALIFY,
		STEP_DONE,
		STEP_TIMEOUT
	} reset_step_t;

endpackage

`default_nettype wire

//--- verilog/gt_link_wrap.sv
`timescale 1ns/100ps
`default_nettype none

`include "gt_link_defines.svh"

module gt_link_wrap
	import gt_link_pkg::*;
(
	input wire RXUSRCLK,
	input wire reset,
	input wire gt_data_t tx_data,
	input wire gt_kmask_t tx_charisk,
	input wire rx_user_ready,
	input wire rx_signal_loss,
	output gt_data_t rx_data,
	output gt_kmask_t rx_charisk,
	output gt_kmask_t rx_disperr,
	output gt_kmask_t rx_notintable,
	output logic reset_done,
	output logic locked,
	output logic cdr_lock
);

	localparam int NSTEP = 3;

	logic [NSTEP-1:0] reset_out;
	logic [NSTEP-1:0] step_done;
	logic [NSTEP-1:0] done_criteria;

	logic cpll_reset;
	logic gt_reset;
	logic cpll_lock;
	logic tx_reset_done;
	logic rx_reset_done;
	logic txrx_reset_done;

	gt_data_t gt_tx_data;
	gt_kmask_t gt_tx_charisk;
	logic gt_rx_user_ready;

	// Step 0 is the PLL, steps 1 and 2 run the datapath reset twice
	assign cpll_reset = reset_out[0];
	assign gt_reset = reset_out[1] | reset_out[2];

	assign txrx_reset_done = tx_reset_done & rx_reset_done & cpll_lock;
	assign done_criteria = {txrx_reset_done, txrx_reset_done, cpll_lock};
	assign reset_done = &step_done & txrx_reset_done;

	// Comma idle until the lane is up
	assign gt_tx_data = reset_done ? tx_data : `GT_IDLE_WORD;
	assign gt_tx_charisk = reset_done ? tx_charisk : `GT_IDLE_KMASK;

	assign gt_rx_user_ready = rx_user_ready & locked;

	chain_reset #(
		.NSTEP(NSTEP)
	) chain_reset_i (
		.RXUSRCLK(RXUSRCLK),
		.reset(reset),
		.done_criteria(done_criteria),
		.reset_out(reset_out),
		.done(step_done)
	);

	cdr_lock_filter cdr_lock_filter_i (
		.RXUSRCLK(RXUSRCLK),
		.reset(reset),
		.cdr_lock(cdr_lock),
		.locked(locked)
	);

	gt_channel_model gt_channel_model_i (
		.RXUSRCLK(RXUSRCLK),
		.reset(reset),
		.cpll_reset(cpll_reset),
		.gt_reset(gt_reset),
		.rx_signal_loss(rx_signal_loss),
		.rx_user_ready(gt_rx_user_ready),
		.tx_data(gt_tx_data),
		.tx_charisk(gt_tx_charisk),
		.cpll_lock(cpll_lock),
		.tx_reset_done(tx_reset_done),
		.rx_reset_done(rx_reset_done),
		.cdr_lock(cdr_lock),
		.rx_data(rx_data),
		.rx_charisk(rx_charisk),
		.rx_disperr(rx_disperr),
		.rx_notintable(rx_notintable)
	);

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
verilog/gt_link_pkg.sv
verilog/chain_reset.sv
verilog/cdr_lock_filter.sv
verilog/gt_channel_model.sv
verilog/gt_link_wrap.sv
verification/gt_link_tb.sv
